// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

	////////////////////////////////////////////////////////////
	// Scratchpad array geometry

	// Word width shared by both RAM ports and the bus data path
	localparam int DATA_WIDTH = 32;

	// Number of words in the scratchpad
	localparam int DEPTH = 256;

	// Word address width, also the memory part of the bus address
	localparam int ADDR_BITS = $clog2(DEPTH);

	////////////////////////////////////////////////////////////
	// Read timing

	// Cycles from a port enable to valid dout on that port
	// 1 means a single output register
	// 2 adds a second pipeline stage behind it
	localparam int READ_LATENCY = 1;

endpackage

`default_nettype wire

// File: common/wb_pkg.sv
`default_nettype none

package wb_pkg;

	////////////////////////////////////////////////////////////
	// Bus address map

	// Word address width on the Wishbone side
	// Top bit picks the register window, the rest index memory words
	localparam int WB_ADR_BITS = 9;

	// Register offsets inside the register window
	localparam logic [WB_ADR_BITS-2:0] REG_BASE   = 8'd0;
	localparam logic [WB_ADR_BITS-2:0] REG_LENGTH = 8'd1;
	localparam logic [WB_ADR_BITS-2:0] REG_VALUE  = 8'd2;
	localparam logic [WB_ADR_BITS-2:0] REG_CMD    = 8'd3;
	localparam logic [WB_ADR_BITS-2:0] REG_STATUS = 8'd4;
	localparam logic [WB_ADR_BITS-2:0] REG_RESULT = 8'd5;

	////////////////////////////////////////////////////////////
	// Engine command and FSM encodings

	// Opcode field, low two bits of a REG_CMD write
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_FILL = 2'd1,
		OP_SUM  = 2'd2
	} engine_op_e;

	// Bus slave FSM
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_READ_WAIT,
		BR_ACK
	} bridge_state_e;

	// Block engine FSM
	typedef enum logic [1:0] {
		EN_IDLE,
		EN_FILL,
		EN_SUM_ISSUE,
		EN_SUM_DRAIN
	} engine_state_e;

endpackage

`default_nettype wire

// File: hdl/dp_ram.sv
`default_nettype none

module dp_ram #(
	parameter int WIDTH        = 32,
	parameter int DEPTH        = 256,
	parameter int READ_LATENCY = 1
) (
	input wire                       porta_clk,

	input wire                       a_en,
	input wire                       a_we,
	input wire [$clog2(DEPTH)-1:0]   a_addr,
	input wire [WIDTH-1:0]           a_din,
	output logic [WIDTH-1:0]         a_dout,

	input wire                       b_en,
	input wire                       b_we,
	input wire [$clog2(DEPTH)-1:0]   b_addr,
	input wire [WIDTH-1:0]           b_din,
	output logic [WIDTH-1:0]         b_dout
);

	// Only one or two output stages exist
	if (READ_LATENCY != 1 && READ_LATENCY != 2) begin : g_bad_latency
		$error("dp_ram READ_LATENCY must be 1 or 2");
	end

	////////////////////////////////////////////////////////////
	// Storage

	logic [WIDTH-1:0] mem [DEPTH];

	// Array powers up cleared
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Both write ports on the one clock
	// Same-address writes in one cycle are not resolved
	always @(posedge porta_clk) begin
		if (a_en && a_we) begin
			mem[a_addr] <= a_din;
		end
		if (b_en && b_we) begin
			mem[b_addr] <= b_din;
		end
	end

	////////////////////////////////////////////////////////////
	// Read pipelines

	// Index 0 is port A, index 1 is port B
	logic                     rd_en   [2];
	logic [$clog2(DEPTH)-1:0] rd_addr [2];
	logic [WIDTH-1:0]         rd_dout [2];

	assign rd_en[0]   = a_en;
	assign rd_en[1]   = b_en;
	assign rd_addr[0] = a_addr;
	assign rd_addr[1] = b_addr;
	assign a_dout     = rd_dout[0];
	assign b_dout     = rd_dout[1];

	for (genvar p = 0; p < 2; p++) begin : g_port
		logic [WIDTH-1:0] stage1;

		// First stage holds its word until the next enable
		always_ff @(posedge porta_clk) begin
			if (rd_en[p]) begin
				stage1 <= mem[rd_addr[p]];
			end
		end

		if (READ_LATENCY == 2) begin : g_two_stage
			logic [WIDTH-1:0] stage2;

			// Free running second stage
			always_ff @(posedge porta_clk) begin
				stage2 <= stage1;
			end
			assign rd_dout[p] = stage2;
		end else begin : g_one_stage
			assign rd_dout[p] = stage1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/wb_ram_bridge.sv
`default_nettype none

module wb_ram_bridge (
	input wire                                porta_clk,
	input wire                                rst_n,

	input wire                                wb_cyc,
	input wire                                wb_stb,
	input wire                                wb_we,
	input wire [wb_pkg::WB_ADR_BITS-1:0]      wb_adr,
	input wire [mem_pkg::DATA_WIDTH-1:0]      wb_dat_i,
	output logic [mem_pkg::DATA_WIDTH-1:0]    wb_dat_o,
	output logic                              wb_ack,

	output logic                              ram_a_en,
	output logic                              ram_a_we,
	output logic [mem_pkg::ADDR_BITS-1:0]     ram_a_addr,
	output logic [mem_pkg::DATA_WIDTH-1:0]    ram_a_din,
	input wire [mem_pkg::DATA_WIDTH-1:0]      ram_a_dout,

	output logic                              eng_start,
	output wb_pkg::engine_op_e                eng_op,
	output logic [mem_pkg::ADDR_BITS-1:0]     eng_base,
	output logic [mem_pkg::ADDR_BITS:0]       eng_length,
	output logic [mem_pkg::DATA_WIDTH-1:0]    eng_value,
	input wire                                eng_busy,
	input wire [mem_pkg::DATA_WIDTH-1:0]      eng_result
);

	wb_pkg::bridge_state_e                 state;
	logic [1:0]                            wait_cnt;
	logic [mem_pkg::DATA_WIDTH-1:0]        base_q;
	logic [mem_pkg::DATA_WIDTH-1:0]        length_q;
	logic [mem_pkg::DATA_WIDTH-1:0]        value_q;
	logic [mem_pkg::DATA_WIDTH-1:0]        reg_rdata;
	logic [wb_pkg::WB_ADR_BITS-2:0]        word_idx;
	logic                                  reg_win;
	logic                                  req;

	////////////////////////////////////////////////////////////
	// Decode

	// New transfers are only taken from idle
	assign req      = wb_cyc && wb_stb && (state == wb_pkg::BR_IDLE);
	assign reg_win  = wb_adr[wb_pkg::WB_ADR_BITS-1];
	assign word_idx = wb_adr[wb_pkg::WB_ADR_BITS-2:0];

	// Port A is driven straight from the bus in the request cycle
	assign ram_a_en   = req && !reg_win;
	assign ram_a_we   = ram_a_en && wb_we;
	assign ram_a_addr = word_idx;
	assign ram_a_din  = wb_dat_i;

	// One ack cycle per transfer
	assign wb_ack = (state == wb_pkg::BR_ACK);

	// Engine sees the low bits of the setup registers
	assign eng_base   = base_q[mem_pkg::ADDR_BITS-1:0];
	assign eng_length = length_q[mem_pkg::ADDR_BITS:0];
	assign eng_value  = value_q;

	// Register readback mux
	always_comb begin
		case (word_idx)
			wb_pkg::REG_BASE:   reg_rdata = base_q;
			wb_pkg::REG_LENGTH: reg_rdata = length_q;
			wb_pkg::REG_VALUE:  reg_rdata = value_q;
			wb_pkg::REG_CMD:    reg_rdata = {{(mem_pkg::DATA_WIDTH-2){1'b0}}, eng_op};
			wb_pkg::REG_STATUS: reg_rdata = {{(mem_pkg::DATA_WIDTH-1){1'b0}}, eng_busy};
			wb_pkg::REG_RESULT: reg_rdata = eng_result;
			default:            reg_rdata = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Transfer FSM and setup registers

	always_ff @(posedge porta_clk) begin
		if (!rst_n) begin
			state     <= wb_pkg::BR_IDLE;
			wait_cnt  <= '0;
			eng_start <= 1'b0;
			eng_op    <= wb_pkg::OP_NONE;
			base_q    <= '0;
			length_q  <= '0;
			value_q   <= '0;
		end else begin
			// Start is a single cycle strobe
			eng_start <= 1'b0;
			case (state)
				wb_pkg::BR_IDLE: begin
					if (req && reg_win) begin
						if (wb_we) begin
							case (word_idx)
								wb_pkg::REG_BASE:   base_q   <= wb_dat_i;
								wb_pkg::REG_LENGTH: length_q <= wb_dat_i;
								wb_pkg::REG_VALUE:  value_q  <= wb_dat_i;
								wb_pkg::REG_CMD: begin
									// Forwarded even while busy, engine decides
									eng_start <= 1'b1;
									eng_op    <= wb_pkg::engine_op_e'(wb_dat_i[1:0]);
								end
								default: begin
									// Writes to read-only offsets are dropped
								end
							endcase
						end
						state <= wb_pkg::BR_ACK;
					end else if (req && wb_we) begin
						state <= wb_pkg::BR_ACK;
					end else if (req) begin
						// Memory read, wait out the RAM latency
						wait_cnt <= 2'(mem_pkg::READ_LATENCY - 1);
						state    <= wb_pkg::BR_READ_WAIT;
					end
				end
				wb_pkg::BR_READ_WAIT: begin
					if (wait_cnt == 2'd0) begin
						state <= wb_pkg::BR_ACK;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				end
				wb_pkg::BR_ACK: state <= wb_pkg::BR_IDLE;
				default:        state <= wb_pkg::BR_IDLE;
			endcase
		end
	end

	// Read data, captured the cycle before ack
	always_ff @(posedge porta_clk) begin
		if (req && reg_win && !wb_we) begin
			wb_dat_o <= reg_rdata;
		end else if (state == wb_pkg::BR_READ_WAIT && wait_cnt == 2'd0) begin
			wb_dat_o <= ram_a_dout;
		end
	end

endmodule

`default_nettype wire

// File: block_engine/block_engine.sv
`default_nettype none

module block_engine (
	input wire                                porta_clk,
	input wire                                rst_n,

	input wire                                eng_start,
	input var wb_pkg::engine_op_e             eng_op,
	input wire [mem_pkg::ADDR_BITS-1:0]       eng_base,
	input wire [mem_pkg::ADDR_BITS:0]         eng_length,
	input wire [mem_pkg::DATA_WIDTH-1:0]      eng_value,
	output logic                              eng_busy,
	output logic [mem_pkg::DATA_WIDTH-1:0]    eng_result,

	output logic                              ram_b_en,
	output logic                              ram_b_we,
	output logic [mem_pkg::ADDR_BITS-1:0]     ram_b_addr,
	output logic [mem_pkg::DATA_WIDTH-1:0]    ram_b_din,
	input wire [mem_pkg::DATA_WIDTH-1:0]      ram_b_dout
);

	wb_pkg::engine_state_e                   state;
	logic [mem_pkg::ADDR_BITS-1:0]           addr_q;
	logic [mem_pkg::ADDR_BITS:0]             remain_q;
	logic [mem_pkg::DATA_WIDTH-1:0]          value_q;

	// One bit per read in flight, oldest at the top
	logic [mem_pkg::READ_LATENCY-1:0]        vld_q;
	logic [mem_pkg::READ_LATENCY:0]          vld_ext;

	logic                                    fill_go;
	logic                                    issue;
	logic                                    accept;

	////////////////////////////////////////////////////////////
	// Port B drive

	// A start while busy is simply not seen
	assign accept  = eng_start && (state == wb_pkg::EN_IDLE);

	assign fill_go = (state == wb_pkg::EN_FILL) && (remain_q != '0);
	assign issue   = (state == wb_pkg::EN_SUM_ISSUE) && (remain_q != '0);

	assign ram_b_en   = fill_go || issue;
	assign ram_b_we   = fill_go;
	assign ram_b_addr = addr_q;
	assign ram_b_din  = value_q;

	assign eng_busy = (state != wb_pkg::EN_IDLE);

	// Top bit marks a read whose data is on ram_b_dout this cycle
	assign vld_ext = {vld_q, issue};

	////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge porta_clk) begin
		if (!rst_n) begin
			state      <= wb_pkg::EN_IDLE;
			remain_q   <= '0;
			vld_q      <= '0;
			eng_result <= '0;
		end else begin
			vld_q <= vld_ext[mem_pkg::READ_LATENCY-1:0];

			// Accumulate returning words, wraps modulo 2^32
			if (vld_ext[mem_pkg::READ_LATENCY]) begin
				eng_result <= eng_result + ram_b_dout;
			end

			// One word per port B access
			if (ram_b_en) begin
				remain_q <= remain_q - 1'b1;
			end

			case (state)
				wb_pkg::EN_IDLE: begin
					if (accept) begin
						remain_q <= eng_length;
						if (eng_op == wb_pkg::OP_FILL) begin
							state <= wb_pkg::EN_FILL;
						end else if (eng_op == wb_pkg::OP_SUM) begin
							state      <= wb_pkg::EN_SUM_ISSUE;
							eng_result <= '0;
						end
						// OP_NONE and unknown codes leave the engine idle
					end
				end

				// Length 0 lands here with nothing to write
				wb_pkg::EN_FILL: begin
					if (remain_q <= 1) begin
						state <= wb_pkg::EN_IDLE;
					end
				end

				wb_pkg::EN_SUM_ISSUE: begin
					if (remain_q == '0) begin
						state <= wb_pkg::EN_IDLE;
					end else if (remain_q == 1) begin
						// Last read issued, collect the tail
						state <= wb_pkg::EN_SUM_DRAIN;
					end
				end

				// Leave once the landing word is the last one in flight
				wb_pkg::EN_SUM_DRAIN: begin
					if (vld_ext[mem_pkg::READ_LATENCY-1:0] == '0) begin
						state <= wb_pkg::EN_IDLE;
					end
				end

				default: state <= wb_pkg::EN_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Address and fill data

	// Address wraps at DEPTH by its width
	always_ff @(posedge porta_clk) begin
		if (accept) begin
			addr_q  <= eng_base;
			value_q <= eng_value;
		end else if (ram_b_en) begin
			addr_q <= addr_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/scratchpad_top.sv
`default_nettype none

module scratchpad_top (
	input wire                                porta_clk,
	input wire                                rst_n,
	input wire                                wb_cyc,
	input wire                                wb_stb,
	input wire                                wb_we,
	input wire [wb_pkg::WB_ADR_BITS-1:0]      wb_adr,
	input wire [mem_pkg::DATA_WIDTH-1:0]      wb_dat_i,
	output logic [mem_pkg::DATA_WIDTH-1:0]    wb_dat_o,
	output logic                              wb_ack
);

	////////////////////////////////////////////////////////////
	// Interconnect

	// Port A, host side
	logic                              ram_a_en;
	logic                              ram_a_we;
	logic [mem_pkg::ADDR_BITS-1:0]     ram_a_addr;
	logic [mem_pkg::DATA_WIDTH-1:0]    ram_a_din;
	logic [mem_pkg::DATA_WIDTH-1:0]    ram_a_dout;

	// Port B, engine side
	logic                              ram_b_en;
	logic                              ram_b_we;
	logic [mem_pkg::ADDR_BITS-1:0]     ram_b_addr;
	logic [mem_pkg::DATA_WIDTH-1:0]    ram_b_din;
	logic [mem_pkg::DATA_WIDTH-1:0]    ram_b_dout;

	// Engine setup and status
	logic                              eng_start;
	wb_pkg::engine_op_e                eng_op;
	logic [mem_pkg::ADDR_BITS-1:0]     eng_base;
	logic [mem_pkg::ADDR_BITS:0]       eng_length;
	logic [mem_pkg::DATA_WIDTH-1:0]    eng_value;
	logic                              eng_busy;
	logic [mem_pkg::DATA_WIDTH-1:0]    eng_result;

	dp_ram #(
		.WIDTH        (mem_pkg::DATA_WIDTH),
		.DEPTH        (mem_pkg::DEPTH),
		.READ_LATENCY (mem_pkg::READ_LATENCY)
	) ram0 (
		.porta_clk (porta_clk),
		.a_en      (ram_a_en),
		.a_we      (ram_a_we),
		.a_addr    (ram_a_addr),
		.a_din     (ram_a_din),
		.a_dout    (ram_a_dout),
		.b_en      (ram_b_en),
		.b_we      (ram_b_we),
		.b_addr    (ram_b_addr),
		.b_din     (ram_b_din),
		.b_dout    (ram_b_dout)
	);

	wb_ram_bridge bridge0 (
		.porta_clk  (porta_clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack),
		.ram_a_en   (ram_a_en),
		.ram_a_we   (ram_a_we),
		.ram_a_addr (ram_a_addr),
		.ram_a_din  (ram_a_din),
		.ram_a_dout (ram_a_dout),
		.eng_start  (eng_start),
		.eng_op     (eng_op),
		.eng_base   (eng_base),
		.eng_length (eng_length),
		.eng_value  (eng_value),
		.eng_busy   (eng_busy),
		.eng_result (eng_result)
	);

	block_engine engine0 (
		.porta_clk  (porta_clk),
		.rst_n      (rst_n),
		.eng_start  (eng_start),
		.eng_op     (eng_op),
		.eng_base   (eng_base),
		.eng_length (eng_length),
		.eng_value  (eng_value),
		.eng_busy   (eng_busy),
		.eng_result (eng_result),
		.ram_b_en   (ram_b_en),
		.ram_b_we   (ram_b_we),
		.ram_b_addr (ram_b_addr),
		.ram_b_din  (ram_b_din),
		.ram_b_dout (ram_b_dout)
	);

endmodule

`default_nettype wire

// File: tb/scratchpad_properties.sv
`default_nettype none

module scratchpad_properties (
	input wire porta_clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire eng_start,
	input wire eng_busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions so far, read by the testbench at the end
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// Wishbone handshake

	// Ack only inside an active strobe
	ack_in_cycle: assert property (@(posedge porta_clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
	else begin
		fail_count++;
		$error("wb_ack seen without cyc and stb");
	end

	// One ack cycle per transfer
	ack_one_cycle: assert property (@(posedge porta_clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
	else begin
		fail_count++;
		$error("wb_ack high for two cycles in a row");
	end

	// Reset clears the ack flop
	ack_reset: assert property (@(posedge porta_clk) !rst_n |=> !wb_ack)
	else begin
		fail_count++;
		$error("wb_ack not low after reset");
	end

	////////////////////////////////////////////////////////////
	// Engine status

	// Busy only follows an accepted start
	busy_from_start: assert property (@(posedge porta_clk) disable iff (!rst_n)
		$rose(eng_busy) |-> $past(eng_start))
	else begin
		fail_count++;
		$error("eng_busy rose without a start pulse");
	end

endmodule

`default_nettype wire

// File: tb/scratchpad_checker.sv
`default_nettype none

module scratchpad_checker (
	input wire                                porta_clk,
	input wire                                rst_n,

	// Bus side of the DUT
	input wire                                wb_ack,
	input wire [mem_pkg::DATA_WIDTH-1:0]      wb_dat_o,

	// Expectation for the read in progress
	input wire                                check_en,
	input wire [mem_pkg::DATA_WIDTH-1:0]      check_exp,
	input wire [8*20-1:0]                     check_name,

	output int                                check_count,
	output int                                mismatch_count
);
	timeunit 1ns;
	timeprecision 100ps;

	////////////////////////////////////////////////////////////
	// Read data compare

	// Data is registered one cycle before ack, so it is stable here
	always @(posedge porta_clk) begin
		if (!rst_n) begin
			check_count    <= 0;
			mismatch_count <= 0;
		end else if (check_en && wb_ack) begin
			check_count <= check_count + 1;
			// X or Z on the bus counts as wrong too
			if (wb_dat_o !== check_exp) begin
				$display("Mismatch %0s: expected %08h, actual %08h",
					check_name, check_exp, wb_dat_o);
				mismatch_count <= mismatch_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/scratchpad_tb.sv
`default_nettype none

module scratchpad_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ACK_LIMIT  = 20;
	localparam int POLL_LIMIT = 100;
	localparam int NAME_BITS  = 8 * 20;

	// What one table entry does on the bus
	typedef enum {K_WRITE, K_READ, K_FILL, K_SUM, K_WAIT_IDLE, K_WAIT_RESULT} kind_e;

	typedef struct {
		logic [NAME_BITS-1:0] name;
		kind_e                kind;
		logic [8:0]           addr;
		logic [31:0]          data;
		logic [31:0]          exp_val;
	} entry_t;

	logic                 porta_clk;
	logic                 rst_n;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [8:0]           wb_adr;
	logic [31:0]          wb_dat_i;
	logic [31:0]          wb_dat_o;
	logic                 wb_ack;

	// Expectation handed to the checker
	logic                 check_en;
	logic [31:0]          check_exp;
	logic [NAME_BITS-1:0] check_name;
	int                   check_count;
	int                   mismatch_count;

	entry_t               stim_q[$];
	logic [31:0]          shadow [256];
	int                   reads_expected;
	int                   errors;

	scratchpad_top dut0 (
		.porta_clk (porta_clk),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack    (wb_ack)
	);

	scratchpad_checker checker0 (
		.porta_clk      (porta_clk),
		.rst_n          (rst_n),
		.wb_ack         (wb_ack),
		.wb_dat_o       (wb_dat_o),
		.check_en       (check_en),
		.check_exp      (check_exp),
		.check_name     (check_name),
		.check_count    (check_count),
		.mismatch_count (mismatch_count)
	);

	bind scratchpad_top scratchpad_properties props0 (
		.porta_clk (porta_clk),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_ack    (wb_ack),
		.eng_start (eng_start),
		.eng_busy  (eng_busy)
	);

	initial begin
		porta_clk = 1'b0;
		forever #2 porta_clk = ~porta_clk;
	end

	////////////////////////////////////////////////////////////
	// Table building, shadow memory gives the expected values

	task automatic add_entry(input logic [NAME_BITS-1:0] name, input kind_e kind,
			input logic [8:0] addr, input logic [31:0] data, input logic [31:0] exp_val);
		stim_q.push_back('{name, kind, addr, data, exp_val});
		if (kind == K_READ || kind == K_WAIT_RESULT) begin
			reads_expected++;
		end
	endtask

	task automatic mem_write(input logic [NAME_BITS-1:0] name, input logic [7:0] addr,
			input logic [31:0] data);
		shadow[addr] = data;
		add_entry(name, K_WRITE, {1'b0, addr}, data, '0);
	endtask

	task automatic mem_read(input logic [NAME_BITS-1:0] name, input logic [7:0] addr);
		add_entry(name, K_READ, {1'b0, addr}, '0, shadow[addr]);
	endtask

	// Sum of the shadow words, wraps at 2^32 and at the array end
	function automatic logic [31:0] range_sum(input logic [7:0] base, input int len);
		logic [31:0] acc;
		acc = '0;
		for (int i = 0; i < len; i++) begin
			acc = acc + shadow[8'(base + i)];
		end
		return acc;
	endfunction

	task automatic fill_range(input logic [7:0] base, input int len, input logic [31:0] value);
		add_entry("fill base", K_WRITE, {1'b1, wb_pkg::REG_BASE}, 32'(base), '0);
		add_entry("fill length", K_WRITE, {1'b1, wb_pkg::REG_LENGTH}, 32'(len), '0);
		add_entry("fill value", K_WRITE, {1'b1, wb_pkg::REG_VALUE}, value, '0);
		add_entry("fill start", K_FILL, '0, '0, '0);
		add_entry("fill done", K_WAIT_IDLE, '0, '0, '0);
		for (int i = 0; i < len; i++) begin
			shadow[8'(base + i)] = value;
		end
	endtask

	// Optional second command lands while the sum is still running
	task automatic sum_range(input logic [NAME_BITS-1:0] name, input logic [7:0] base,
			input int len, input bit cmd_while_busy);
		add_entry("sum base", K_WRITE, {1'b1, wb_pkg::REG_BASE}, 32'(base), '0);
		add_entry("sum length", K_WRITE, {1'b1, wb_pkg::REG_LENGTH}, 32'(len), '0);
		add_entry("sum start", K_SUM, '0, '0, '0);
		if (cmd_while_busy) begin
			add_entry("cmd while busy", K_FILL, '0, '0, '0);
		end
		add_entry(name, K_WAIT_RESULT, '0, '0, range_sum(base, len));
	endtask

	task automatic build_stimulus();
		logic [7:0] a;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = '0;
		end
		// Engine registers straight out of reset
		add_entry("status after reset", K_READ, {1'b1, wb_pkg::REG_STATUS}, '0, '0);
		add_entry("result after reset", K_READ, {1'b1, wb_pkg::REG_RESULT}, '0, '0);
		// Setup register readback
		add_entry("base write", K_WRITE, {1'b1, wb_pkg::REG_BASE}, 32'h0000_00c3, '0);
		add_entry("base readback", K_READ, {1'b1, wb_pkg::REG_BASE}, '0, 32'h0000_00c3);
		add_entry("length write", K_WRITE, {1'b1, wb_pkg::REG_LENGTH}, 32'h0000_0117, '0);
		add_entry("length readback", K_READ, {1'b1, wb_pkg::REG_LENGTH}, '0, 32'h0000_0117);
		add_entry("value write", K_WRITE, {1'b1, wb_pkg::REG_VALUE}, 32'hdead_beef, '0);
		add_entry("value readback", K_READ, {1'b1, wb_pkg::REG_VALUE}, '0, 32'hdead_beef);
		// Random words in the middle of the array
		for (int i = 0; i < 4; i++) begin
			a = 8'(100 + ($urandom % 100));
			mem_write("rand write", a, $urandom);
			mem_read("rand read", a);
		end
		// Random block around the wrap point, 248 up through 7
		for (int i = 0; i < 16; i++) begin
			mem_write("wrap write", 8'(248 + i), $urandom);
		end
		mem_read("addr 255 read", 8'd255);
		mem_read("addr 0 read", 8'd0);
		sum_range("wrap sum", 8'd250, 10, 1'b0);
		// Fill 16 to 23 with marked neighbors on both sides
		mem_write("below fill", 8'd15, 32'h1111_0015);
		mem_write("above fill", 8'd24, 32'h2222_0024);
		fill_range(8'd16, 8, 32'ha5a5_5a5a);
		for (int i = 15; i <= 24; i++) begin
			mem_read("fill check", 8'(i));
		end
		sum_range("fill sum", 8'd15, 10, 1'b0);
		sum_range("zero sum", 8'd40, 0, 1'b0);
		// Fill command during a sum must not touch the block
		sum_range("busy sum", 8'd248, 16, 1'b1);
		mem_read("no refill low", 8'd248);
		mem_read("no refill high", 8'd7);
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone master

	task automatic bus_xfer(input logic we, input logic [8:0] adr, input logic [31:0] dat,
			input logic check, input logic [31:0] exp_val,
			input logic [NAME_BITS-1:0] name, output logic [31:0] rdata);
		bit got;
		int n;
		got   = 1'b0;
		rdata = '0;
		@(posedge porta_clk);
		wb_cyc     <= 1'b1;
		wb_stb     <= 1'b1;
		wb_we      <= we;
		wb_adr     <= adr;
		wb_dat_i   <= dat;
		check_en   <= check;
		check_exp  <= exp_val;
		check_name <= name;
		for (n = 0; n < ACK_LIMIT && !got; n++) begin
			@(posedge porta_clk);
			if (wb_ack) begin
				got   = 1'b1;
				rdata = wb_dat_o;
			end
		end
		// Strobe drops right after the ack cycle
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		wb_we    <= 1'b0;
		check_en <= 1'b0;
		if (!got) begin
			errors++;
			$display("Error: %0s got no bus acknowledge within %0d cycles", name, ACK_LIMIT);
		end
	endtask

	// Status polling, bit 0 is busy
	task automatic wait_idle(input logic [NAME_BITS-1:0] name);
		logic [31:0] st;
		bit idle;
		int n;
		idle = 1'b0;
		for (n = 0; n < POLL_LIMIT && !idle; n++) begin
			bus_xfer(1'b0, {1'b1, wb_pkg::REG_STATUS}, '0, 1'b0, '0, name, st);
			idle = (st[0] === 1'b0);
		end
		if (!idle) begin
			errors++;
			$display("Error: %0s engine still busy after %0d status polls", name, POLL_LIMIT);
		end
	endtask

	task automatic run_entry(input entry_t e);
		logic [31:0] rd;
		case (e.kind)
			K_WRITE: bus_xfer(1'b1, e.addr, e.data, 1'b0, '0, e.name, rd);
			K_READ:  bus_xfer(1'b0, e.addr, '0, 1'b1, e.exp_val, e.name, rd);
			K_FILL:  bus_xfer(1'b1, {1'b1, wb_pkg::REG_CMD}, 32'(wb_pkg::OP_FILL),
				1'b0, '0, e.name, rd);
			K_SUM:   bus_xfer(1'b1, {1'b1, wb_pkg::REG_CMD}, 32'(wb_pkg::OP_SUM),
				1'b0, '0, e.name, rd);
			K_WAIT_IDLE: wait_idle(e.name);
			default: begin
				wait_idle(e.name);
				bus_xfer(1'b0, {1'b1, wb_pkg::REG_RESULT}, '0, 1'b1, e.exp_val, e.name, rd);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'he075_6a38));
		rst_n          = 1'b0;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = '0;
		wb_dat_i       = '0;
		check_en       = 1'b0;
		check_exp      = '0;
		check_name     = '0;
		errors         = 0;
		reads_expected = 0;
		build_stimulus();
		repeat (2) @(posedge porta_clk);
		rst_n <= 1'b1;
		foreach (stim_q[i]) begin
			run_entry(stim_q[i]);
		end
		repeat (2) @(posedge porta_clk);
		// Every read in the table must have reached the checker
		if (check_count != reads_expected) begin
			errors++;
			$display("Error: only %0d of %0d reads were checked", check_count, reads_expected);
		end
		$display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
			check_count, mismatch_count, errors, dut0.props0.fail_count);
		if (mismatch_count == 0 && errors == 0 && dut0.props0.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/mem_pkg.sv
common/wb_pkg.sv
hdl/dp_ram.sv
hdl/wb_ram_bridge.sv
block_engine/block_engine.sv
hdl/scratchpad_top.sv
tb/scratchpad_properties.sv
tb/scratchpad_checker.sv
tb/scratchpad_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module scratchpad_tb \
	-f filelist.f -o scratchpad_sim \
	&& ./obj_dir/scratchpad_sim > sim.log 2>&1

cat sim.log 2>/dev/null

# The log decides the outcome
grep -q "All tests passed!" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
